// File: vlog.f
+incdir+verilog
verilog/powerIsaPkg.sv
verilog/decodePkg.sv
verilog/payloadQueue.sv
verilog/branchDecoder.sv
verilog/branchDecodeUnit.sv
testbench/branchDecode_chk.sv
testbench/branchDecodeTb.sv

// File: testbench/branchDecodeTb.sv
`default_nettype none

`include "decode_macros.svh"

// random branch/non-branch traffic against a behavioral decode model
module branchDecodeTb;

    import powerIsaPkg::*;
    import decodePkg::*;

    localparam int CLK_PERIOD     = 10;
    localparam int DRIVE_DELAY    = 1;    // inputs change just after the edge
    localparam int NUM_INST       = 400;
    localparam int SEED           = 38;
    localparam int DRAIN_CYCLES   = `FETCH_DEPTH + `ISSUE_DEPTH + 4;
    localparam int TIMEOUT_CYCLES = NUM_INST * 20 + 500;

    logic                    clock_i;
    logic                    reset_i;
    logic                    fetchValid_i;
    logic                    fetchReady_o;
    fetchedInstT             fetch_i;
    logic                    issueValid_o;
    logic                    issueReady_i;
    decodedInstT             issue_o;
    logic [`COUNT_WIDTH-1:0] droppedCount_o;

    decodedInstT             expectedQ[$];  // branch records still in flight
    logic [`COUNT_WIDTH-1:0] droppedModel;
    logic [63:0]             majCounter;    // program order tag for new words
    int                      generated;     // words put on the fetch port
    int                      accepted;      // words taken by the DUT
    int                      drainWait;     // cycles spent waiting for the last records
    logic                    fetchTaken;    // handshake seen in the last cycle
    logic                    draining;

    branchDecodeUnit dut_i (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .fetchValid_i   (fetchValid_i),
        .fetchReady_o   (fetchReady_o),
        .fetch_i        (fetch_i),
        .issueValid_o   (issueValid_o),
        .issueReady_i   (issueReady_i),
        .issue_o        (issue_o),
        .droppedCount_o (droppedCount_o)
    );

    initial begin
        clock_i = 1'b0;
        forever #(CLK_PERIOD / 2) clock_i = ~clock_i;
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkIssue(input decodedInstT actual);
        decodedInstT expected;
        if (expectedQ.size() == 0) begin
            failRun($sformatf("a record was issued at time %0t with none expected, majId %h",
                              $time, actual.majId));
        end
        expected = expectedQ.pop_front();
        if (actual !== expected) begin
            failRun($sformatf("error at time %0t: issue_o expected %h, actual %h",
                              $time, expected, actual));
        end
    endtask

    task automatic checkCount(input logic [`COUNT_WIDTH-1:0] actual);
        if (actual !== droppedModel) begin
            failRun($sformatf("error at time %0t: droppedCount_o expected %0d, actual %0d",
                              $time, droppedModel, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("error at time %0t: %s expected %b, actual %b",
                              $time, name, expected, actual));
        end
    endtask

    // word address biased toward the 32-bit and 64-bit wrap points and zero
    function automatic logic [63:0] randomAddress();
        logic [63:0] addr;
        case ($urandom_range(3))
            0:       addr = {$urandom, $urandom};
            1:       addr = 64'h0000_0000_FFFF_FF00 + 64'($urandom_range(127)) * 4;
            2:       addr = 64'hFFFF_FFFF_FFFF_FF00 + 64'($urandom_range(63)) * 4;
            default: addr = 64'($urandom_range(255)) * 4;
        endcase
        addr[1:0] = 2'b00;
        return addr;
    endfunction

    function automatic fetchedInstT randomInst();
        fetchedInstT f;
        logic [31:0] w;
        logic [5:0]  op;
        int          pick;
        pick = $urandom_range(99);
        if (pick < 40) begin
            op = 6'd16;
        end else if (pick < 70) begin
            op = 6'd18;
        end else begin
            case ($urandom_range(2))
                0: op = 6'd0;
                1: op = 6'd63;
                default: begin
                    do begin
                        op = 6'($urandom_range(63));
                    end while (op == 6'd16 || op == 6'd18);
                end
            endcase
        end
        w           = $urandom;
        w[31:26]    = op;          // ISA bits 0..5
        f.instruction = w;
        f.address   = randomAddress();
        f.is64Bit   = 1'($urandom_range(1));
        f.pid       = `PID_WIDTH'($urandom);
        f.tid       = `TID_WIDTH'($urandom);
        f.majId     = majCounter;
        majCounter  = majCounter + 1;
        return f;
    endfunction

    // decode rules written against a plain [31:0] view of the word
    function automatic decodedInstT expectedRecord(input fetchedInstT f);
        decodedInstT        r;
        logic [31:0]        w;
        logic [63:0]        addr;
        logic signed [63:0] disp;
        logic [63:0]        tgt;
        w            = f.instruction;
        addr         = f.address;
        r            = '0;           // minId, bo, bi stay zero unless set
        r.majId      = f.majId;
        r.pid        = f.pid;
        r.tid        = f.tid;
        r.address    = f.address;
        r.primOpcode = w[31:26];
        r.funcUnit   = BRANCH;
        r.absolute   = w[1];         // AA
        r.link       = w[0];         // LK
        if (w[31:26] == 6'd16) begin
            r.form        = FORM_B;
            r.bo          = w[25:21];
            r.bi          = w[20:16];
            r.usesCtr     = !w[23];  // BO bit 2 sits at instruction bit 8
            r.conditional = 1'b1;
            disp          = $signed({w[15:2], 2'b00});
        end else begin
            r.form        = FORM_I;
            disp          = $signed({w[25:2], 2'b00});
        end
        tgt = w[1] ? disp : addr + disp;  // wraps mod 2**64
        if (!f.is64Bit) begin
            tgt[63:32] = '0;
        end
        r.target = tgt;
        return r;
    endfunction

    task automatic modelFetch(input fetchedInstT f);
        logic [31:0] w;
        w = f.instruction;
        if (w[31:26] == 6'd16 || w[31:26] == 6'd18) begin
            expectedQ.push_back(expectedRecord(f));
        end else begin
            droppedModel = droppedModel + 1'b1;
        end
    endtask

    // valid and payload hold until the DUT takes them
    task automatic driveInputs();
        if (!(fetchValid_i && !fetchTaken)) begin
            if (generated < NUM_INST && $urandom_range(3) != 0) begin
                fetch_i      = randomInst();
                fetchValid_i = 1'b1;
                generated++;
            end else begin
                fetchValid_i = 1'b0;
            end
        end
        issueReady_i = draining ? 1'b1 : ($urandom_range(4) != 0);
    endtask

    // drive after the edge and sample at the falling edge where all is settled
    task automatic runCycle();
        @(posedge clock_i);
        #DRIVE_DELAY;
        driveInputs();
        @(negedge clock_i);
        if (dut_i.protocolChk.assertFails != 0) begin
            failRun("a protocol assertion on the issue port failed");
        end
        fetchTaken = fetchValid_i && fetchReady_o;
        if (fetchTaken) begin
            modelFetch(fetch_i);
            accepted++;
        end
        if (issueValid_o && issueReady_i) begin
            checkIssue(issue_o);
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        failRun($sformatf("timeout after %0d cycles, the run hung", TIMEOUT_CYCLES));
    end

    initial begin
        void'($urandom(SEED));
        reset_i      = 1'b1;
        fetchValid_i = 1'b0;
        fetch_i      = '0;
        issueReady_i = 1'b0;
        droppedModel = '0;
        majCounter   = 64'h1000;
        generated    = 0;
        accepted     = 0;
        drainWait    = 0;
        fetchTaken   = 1'b0;
        draining     = 1'b0;

        repeat (5) @(posedge clock_i);
        #DRIVE_DELAY;
        reset_i = 1'b0;
        @(negedge clock_i);
        checkFlag("issueValid_o", 1'b0, issueValid_o);  // idle state after reset
        checkFlag("fetchReady_o", 1'b1, fetchReady_o);
        checkCount(droppedCount_o);

        while (accepted < NUM_INST) begin
            runCycle();
        end
        draining = 1'b1;                                 // no more back-pressure
        while (expectedQ.size() != 0 && drainWait < DRAIN_CYCLES) begin
            runCycle();
            drainWait++;
        end
        repeat (DRAIN_CYCLES) runCycle();                // trailing drops reach the counter
        checkCount(droppedCount_o);
        checkFlag("issueValid_o", 1'b0, issueValid_o);

        if (expectedQ.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            failRun($sformatf("%0d branch records never issued", expectedQ.size()));
        end
    end

endmodule

`default_nettype wire

// File: testbench/branchDecode_chk.sv
`default_nettype none

// issue port protocol and record format checks bound into the top level
module branchDecodeChk (
    input wire logic                   clock_i,
    input wire logic                   reset_i,
    input wire logic                   issueValid_i,
    input wire logic                   issueReady_i,
    input wire decodePkg::decodedInstT issue_i
);

    import powerIsaPkg::*;

    int assertFails = 0; // count of failed assertions

    // a stalled record stays put until the branch unit takes it
    stallHold: assert property (@(posedge clock_i) disable iff (reset_i)
        issueValid_i && !issueReady_i |=> issueValid_i && $stable(issue_i))
        else begin
            assertFails++;
            $error("issue record changed or vanished while stalled");
        end

    resetClear: assert property (@(posedge clock_i) reset_i |=> !issueValid_i)
        else begin
            assertFails++;
            $error("issue valid high right after reset");
        end

    unitBranch: assert property (@(posedge clock_i) disable iff (reset_i)
        issueValid_i |-> issue_i.funcUnit == BRANCH)
        else begin
            assertFails++;
            $error("issued record not routed to the branch unit");
        end

    // I-form is unconditional and never touches CTR
    iFormPlain: assert property (@(posedge clock_i) disable iff (reset_i)
        issueValid_i && issue_i.form == FORM_I |-> !issue_i.usesCtr && !issue_i.conditional)
        else begin
            assertFails++;
            $error("I-form record marked conditional or using CTR");
        end

endmodule

bind branchDecodeUnit branchDecodeChk protocolChk (
    .clock_i      (clock_i),
    .reset_i      (reset_i),
    .issueValid_i (issueValid_o),
    .issueReady_i (issueReady_i),
    .issue_i      (issue_o)
);

`default_nettype wire

// File: verilog/branchDecodeUnit.sv
`default_nettype none

`include "decode_macros.svh"

// fetch queue -> branch decoder -> issue queue
module branchDecodeUnit (
    input  wire logic                   clock_i,
    input  wire logic                   reset_i,
    input  wire logic                   fetchValid_i,
    output logic                        fetchReady_o,
    input  wire decodePkg::fetchedInstT fetch_i,
    output logic                        issueValid_o,
    input  wire logic                   issueReady_i,
    output decodePkg::decodedInstT      issue_o,
    output logic [`COUNT_WIDTH-1:0]     droppedCount_o
);

    import decodePkg::*;

    logic        queuedValid;  // fetch queue head
    logic        queuedReady;
    fetchedInstT queued;
    logic        decodedValid; // decoder register
    logic        decodedReady;
    decodedInstT decoded;

    payloadQueue #(
        .payloadT (fetchedInstT),
        .DEPTH    (`FETCH_DEPTH)
    ) fetchQueue (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .pushValid_i (fetchValid_i),
        .pushReady_o (fetchReady_o),
        .push_i      (fetch_i),
        .popValid_o  (queuedValid),
        .popReady_i  (queuedReady),
        .pop_o       (queued)
    );

    branchDecoder decoder (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .inValid_i      (queuedValid),
        .inReady_o      (queuedReady),
        .in_i           (queued),
        .outValid_o     (decodedValid),
        .outReady_i     (decodedReady),
        .out_o          (decoded),
        .droppedCount_o (droppedCount_o)
    );

    // holds records while the branch unit stalls
    payloadQueue #(
        .payloadT (decodedInstT),
        .DEPTH    (`ISSUE_DEPTH)
    ) issueQueue (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .pushValid_i (decodedValid),
        .pushReady_o (decodedReady),
        .push_i      (decoded),
        .popValid_o  (issueValid_o),
        .popReady_i  (issueReady_i),
        .pop_o       (issue_o)
    );

endmodule

`default_nettype wire

// File: verilog/branchDecoder.sv
`default_nettype none

`include "decode_macros.svh"

// single register stage that recognizes B-form and I-form branches,
// resolves the target and drops everything else
module branchDecoder (
    input  wire logic                   clock_i,
    input  wire logic                   reset_i,
    input  wire logic                   inValid_i,
    output logic                        inReady_o,
    input  wire decodePkg::fetchedInstT in_i,
    output logic                        outValid_o,
    input  wire logic                   outReady_i,
    output decodePkg::decodedInstT      out_o,
    output logic [`COUNT_WIDTH-1:0]     droppedCount_o
);

    import powerIsaPkg::*;
    import decodePkg::*;

    localparam int HALF_ADDR = `ADDR_WIDTH / 2;

    primOpcodeT             primOp;
    logic                   isBc;       // branch conditional
    logic                   isB;        // unconditional branch
    logic                   isBranch;
    logic [0:BD_WIDTH-1]    bd;
    logic [0:LI_WIDTH-1]    li;
    logic [0:`ADDR_WIDTH-1] disp;       // sign extended byte displacement
    decodedInstT            decodeNext; // record to be registered
    logic                   accept;

    // stage can take a word when empty or when its content leaves this cycle
    assign inReady_o = !outValid_o || outReady_i;
    assign accept    = inValid_i && inReady_o;

    always_comb begin
        primOp   = in_i.instruction[PRIM_OP_POS +: $bits(primOpcodeT)];
        isBc     = (primOp == OP_BC);
        isB      = (primOp == OP_B);
        isBranch = isBc || isB;

        bd = in_i.instruction[BD_POS +: BD_WIDTH];
        li = in_i.instruction[LI_POS +: LI_WIDTH];

        // word displacement with two zero lsbs appended and then sign extended
        if (isBc) begin
            disp = {{(`ADDR_WIDTH - BD_WIDTH - 2){bd[0]}}, bd, 2'b00};
        end else begin
            disp = {{(`ADDR_WIDTH - LI_WIDTH - 2){li[0]}}, li, 2'b00};
        end

        decodeNext.majId      = in_i.majId;
        decodeNext.minId      = '0;              // one op per instruction
        decodeNext.pid        = in_i.pid;
        decodeNext.tid        = in_i.tid;
        decodeNext.address    = in_i.address;
        decodeNext.primOpcode = primOp;
        decodeNext.form       = isBc ? FORM_B : FORM_I;
        decodeNext.funcUnit   = BRANCH;

        // condition fields exist only in the B-form
        if (isBc) begin
            decodeNext.bo = in_i.instruction[BO_POS +: $bits(boT)];
            decodeNext.bi = in_i.instruction[BI_POS +: $bits(biT)];
        end else begin
            decodeNext.bo = '0;
            decodeNext.bi = '0;
        end

        decodeNext.absolute    = in_i.instruction[AA_POS];
        decodeNext.link        = in_i.instruction[LK_POS];
        decodeNext.usesCtr     = isBc && !decodeNext.bo[BO_CTR_BIT]; // CTR decrement
        decodeNext.conditional = isBc;

        // relative to the branch unless AA selects an absolute target
        if (decodeNext.absolute) begin
            decodeNext.target = disp;
        end else begin
            decodeNext.target = in_i.address + disp;
        end

        // 32-bit mode clears the upper word of the effective address
        if (!in_i.is64Bit) begin
            decodeNext.target[0 +: HALF_ADDR] = '0;
        end
    end

    // control state
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            outValid_o     <= 1'b0;
            droppedCount_o <= '0;
        end else if (accept) begin
            outValid_o <= isBranch; // a dropped word leaves the stage empty
            if (!isBranch) begin
                droppedCount_o <= droppedCount_o + 1'b1; // wraps
            end
        end else if (outReady_i) begin
            outValid_o <= 1'b0;    // drained with nothing new behind it
        end
    end

    // payload only loads when a branch is taken in
    always_ff @(posedge clock_i) begin
        if (accept && isBranch) begin
            out_o <= decodeNext;
        end
    end

endmodule

`default_nettype wire

// File: verilog/payloadQueue.sv
`default_nettype none

// circular buffer FIFO with valid/ready on both sides
module payloadQueue #(
    parameter type payloadT = logic,
    parameter int  DEPTH    = 4      // 2 or more and not necessarily a power of two
) (
    input  wire logic clock_i,
    input  wire logic reset_i,
    input  wire logic pushValid_i,
    output logic      pushReady_o,
    input  wire       payloadT push_i,
    output logic      popValid_o,
    input  wire logic popReady_i,
    output payloadT   pop_o
);

    localparam int PTR_WIDTH = $clog2(DEPTH);
    localparam int CNT_WIDTH = $clog2(DEPTH + 1); // must hold DEPTH itself

    payloadT              mem [DEPTH];
    logic [PTR_WIDTH-1:0] rdPtr;
    logic [PTR_WIDTH-1:0] wrPtr;
    logic [CNT_WIDTH-1:0] count;      // occupancy
    logic                 full;
    logic                 empty;
    logic                 doPush;
    logic                 doPop;

    // advance a pointer, wrapping at DEPTH
    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count == CNT_WIDTH'(DEPTH));
    assign empty = (count == '0);

    assign pushReady_o = !full || popReady_i; // a full queue takes one when a slot frees
    assign popValid_o  = !empty;
    assign pop_o       = mem[rdPtr];           // head is always at the read pointer

    assign doPush = pushValid_i && pushReady_o;
    assign doPop  = popValid_o && popReady_i;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // idle or one in and one out
            endcase
        end
    end

    // storage whose contents only matter where count says so
    always_ff @(posedge clock_i) begin
        if (doPush) begin
            mem[wrPtr] <= push_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/decodePkg.sv
`default_nettype none

`include "decode_macros.svh"

// records that travel between the decode blocks
package decodePkg;

    // one word as delivered by fetch
    typedef struct packed {
        logic [0:`INST_WIDTH-1]   instruction; // ISA bit order
        logic [0:`ADDR_WIDTH-1]   address;
        logic                     is64Bit;     // clear in 32-bit mode
        logic [0:`PID_WIDTH-1]    pid;
        logic [0:`TID_WIDTH-1]    tid;
        logic [0:`MAJ_ID_WIDTH-1] majId;
    } fetchedInstT;

    // what the branch unit receives
    typedef struct packed {
        logic [0:`MAJ_ID_WIDTH-1] majId;       // copied from fetch
        logic [0:`MIN_ID_WIDTH-1] minId;       // always zero, no cracking
        logic [0:`PID_WIDTH-1]    pid;
        logic [0:`TID_WIDTH-1]    tid;
        logic [0:`ADDR_WIDTH-1]   address;     // address of the branch itself
        powerIsaPkg::primOpcodeT  primOpcode;
        powerIsaPkg::instFormT    form;
        powerIsaPkg::funcUnitT    funcUnit;
        powerIsaPkg::boT          bo;          // zero for I-form
        powerIsaPkg::biT          bi;          // zero for I-form
        logic [0:`ADDR_WIDTH-1]   target;      // resolved branch target
        logic                     absolute;    // AA
        logic                     link;        // LK
        logic                     usesCtr;
        logic                     conditional;
    } decodedInstT;

endpackage

`default_nettype wire

// File: verilog/powerIsaPkg.sv
`default_nettype none

// encodings that come straight from the ISA with nothing pipeline specific
package powerIsaPkg;

    typedef logic [0:5] primOpcodeT; // bits 0..5 of every instruction

    localparam primOpcodeT OP_BC = 6'd16; // branch conditional, B-form
    localparam primOpcodeT OP_B  = 6'd18; // branch, I-form

    typedef enum logic [1:0] {
        FORM_B = 2'd0,
        FORM_I = 2'd1
    } instFormT;

    // backend unit selector
    typedef enum logic [2:0] {
        FX     = 3'd0, // fixed point
        FP     = 3'd1, // floating point
        VX     = 3'd2, // vector
        CR     = 3'd3, // condition register logic
        LS     = 3'd4, // load/store
        BRANCH = 3'd6  // code 5 unused
    } funcUnitT;

    typedef logic [0:4] boT; // branch options
    typedef logic [0:4] biT; // CR bit to test with an offset of 32

    // field positions count bit 0 as the msb like the ISA book
    localparam int PRIM_OP_POS = 0;
    localparam int BO_POS      = 6;
    localparam int BI_POS      = 11;
    localparam int BD_POS      = 16;   // B-form displacement
    localparam int BD_WIDTH    = 14;
    localparam int LI_POS      = 6;    // I-form displacement
    localparam int LI_WIDTH    = 24;
    localparam int AA_POS      = 30;   // absolute address
    localparam int LK_POS      = 31;   // update link register

    // BO bit that selects decrement and test of CTR when clear
    localparam int BO_CTR_BIT  = 2;

endpackage

`default_nettype wire

// File: verilog/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath widths
`define ADDR_WIDTH 64       // effective address
`define INST_WIDTH 32       // fixed 4 byte instruction word

// instruction tags carried down the pipe
`define PID_WIDTH 20        // process id
`define TID_WIDTH 16        // thread id within a process
`define MAJ_ID_WIDTH 64     // program order tag
`define MIN_ID_WIDTH 7      // micro-op index under one major id

// queue sizing at the top level
`define FETCH_DEPTH 4
`define ISSUE_DEPTH 4

// wraps silently and only feeds statistics
`define COUNT_WIDTH 16

`endif
